// ==== include/rv_mc_cfg.svh ====
`ifndef RV_MC_CFG_SVH
`define RV_MC_CFG_SVH

// Data path and address width.
`define RV_XLEN 32

// Architectural registers, x0 included.
`define RV_NREGS 32

// Address of the first instruction fetched after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== source/rv_mc_pkg.sv ====
package rv_mc_pkg;

    //////////////////////////////////////////////////
    // Instruction encodings

    typedef enum logic [6:0] {
        OP_R_TYPE = 7'b0110011,
        OP_I_ALU  = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    //////////////////////////////////////////////////
    // Datapath selects

    typedef enum logic [1:0] {
        SRC_A_PC     = 2'd0,
        SRC_A_OLD_PC = 2'd1,
        SRC_A_REG_1  = 2'd2
    } alu_src_a_e;

    typedef enum logic [1:0] {
        SRC_B_REG_2   = 2'd0,
        SRC_B_EXT_IMM = 2'd1,
        SRC_B_FOUR    = 2'd2
    } alu_src_b_e;

    typedef enum logic [1:0] {
        RES_ALU_OUT    = 2'd0, // Registered ALU result.
        RES_ALU_RESULT = 2'd1, // Live ALU output.
        RES_MEM_DATA   = 2'd2
    } res_src_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_I    = 2'd1,
        IMM_S    = 2'd2,
        IMM_B    = 2'd3
    } imm_src_e;

    typedef enum logic [1:0] {
        DT_WORD = 2'd2 // Byte and half codes would sit below this one.
    } mem_dt_e;

    //////////////////////////////////////////////////
    // Controller states

    typedef enum logic [3:0] {
        FETCH     = 4'd0,
        DECODE    = 4'd1,
        MEM_ADDR  = 4'd2,
        MEM_READ  = 4'd3,
        MEM_WRITE = 4'd4,
        MEM_W_RF  = 4'd5,
        EXEC_R    = 4'd6,
        EXEC_I    = 4'd7,
        ALU_W_RF  = 4'd8,
        BRANCH    = 4'd9,
        HALT      = 4'd10
    } mc_state_e;

endpackage

// ==== source/rv_alu_decoder.sv ====
`timescale 1ns/10ps

module rv_alu_decoder
    import rv_mc_pkg::*;
(
    input  logic [6:0] op,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output alu_op_e    alu_ctrl
);

    logic is_sub;

    // Immediate forms never subtract, whatever sits in the funct7 bits.
    assign is_sub = (op == OP_R_TYPE) && (funct7 == 7'b0100000);

    always_comb begin
        case (funct3)
            3'b000: begin
                if (is_sub) begin
                    alu_ctrl = ALU_SUB;
                end else begin
                    alu_ctrl = ALU_ADD;
                end
            end
            3'b001:  alu_ctrl = ALU_SLL;
            3'b010:  alu_ctrl = ALU_SLT;
            3'b100:  alu_ctrl = ALU_XOR;
            3'b101:  alu_ctrl = ALU_SRL;
            3'b110:  alu_ctrl = ALU_OR;
            3'b111:  alu_ctrl = ALU_AND;
            default: alu_ctrl = ALU_ADD; // sltu is not supported.
        endcase
    end

endmodule

// ==== source/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu
    import rv_mc_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  alu_op_e          alu_ctrl,
    output logic [WIDTH-1:0] result,
    output logic [3:0]       flags
);

    localparam int SHW = $clog2(WIDTH);

    logic             is_sub;
    logic [WIDTH-1:0] b_in;
    logic [WIDTH:0]   sum;
    logic             carry;
    logic             overflow;

    assign is_sub = (alu_ctrl == ALU_SUB);
    assign b_in   = is_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_in} + {{WIDTH{1'b0}}, is_sub}; // Two's complement subtract.

    always_comb begin
        case (alu_ctrl)
            ALU_ADD, ALU_SUB: result = sum[WIDTH-1:0];
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL: result = a << b[SHW-1:0];
            ALU_SRL: result = a >> b[SHW-1:0];
            default: result = '0;
        endcase
    end

    // Carry and overflow only mean something for add and subtract.
    assign carry    = (alu_ctrl == ALU_ADD || is_sub) ? sum[WIDTH] : 1'b0;
    assign overflow = (alu_ctrl == ALU_ADD || is_sub) &&
                      (a[WIDTH-1] == b_in[WIDTH-1]) &&
                      (result[WIDTH-1] != a[WIDTH-1]);

    assign flags = {result == '0, result[WIDTH-1], carry, overflow};

endmodule

// ==== source/rv_mc_controller.sv ====
`timescale 1ns/10ps

module rv_mc_controller
    import rv_mc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [31:0] instr,
    input  logic [3:0] alu_flags,
    output logic       rf_we,
    output logic       m_we,
    output logic       en_ir,
    output logic       en_pc,
    output logic       en_npc_r,
    output logic       m_addr_src,
    output alu_src_a_e alu_src_a,
    output alu_src_b_e alu_src_b,
    output res_src_e   res_src,
    output imm_src_e   imm_src,
    output alu_op_e    alu_ctrl,
    output mem_dt_e    dt,
    output logic       halted
);

    typedef struct packed {
        logic       rf_we;
        logic       m_we;
        logic       en_ir;
        logic       en_npc_r;
        logic       m_addr_src;
        alu_src_a_e src_a;
        alu_src_b_e src_b;
        res_src_e   res;
    } ctrl_t;

    logic [6:0] op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    mc_state_e  state;
    mc_state_e  next_state;
    ctrl_t      ctrl;
    alu_op_e    dec_alu_ctrl;
    logic       zero;
    logic       less;
    logic       taken;

    assign op     = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    //////////////////////////////////////////////////
    // State register and next state

    always_comb begin
        case (state)
            FETCH:    next_state = DECODE;
            DECODE: begin
                case (op)
                    OP_LOAD, OP_STORE: next_state = MEM_ADDR;
                    OP_R_TYPE:         next_state = EXEC_R;
                    OP_I_ALU:          next_state = EXEC_I;
                    OP_BRANCH:         next_state = BRANCH;
                    default:           next_state = HALT;
                endcase
            end
            MEM_ADDR: next_state = (op == OP_LOAD) ? MEM_READ : MEM_WRITE;
            MEM_READ: next_state = MEM_W_RF;
            EXEC_R:   next_state = ALU_W_RF;
            EXEC_I:   next_state = ALU_W_RF;
            HALT:     next_state = HALT; // Only reset leaves this state.
            default:  next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // Output table

    always_comb begin
        case (state)
            FETCH:     ctrl = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                                SRC_A_PC, SRC_B_FOUR, RES_ALU_RESULT};
            DECODE:    ctrl = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                                SRC_A_OLD_PC, SRC_B_EXT_IMM, RES_ALU_OUT};
            MEM_ADDR:  ctrl = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                                SRC_A_REG_1, SRC_B_EXT_IMM, RES_ALU_OUT};
            MEM_READ:  ctrl = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                                SRC_A_REG_1, SRC_B_EXT_IMM, RES_ALU_OUT};
            MEM_WRITE: ctrl = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1,
                                SRC_A_REG_1, SRC_B_EXT_IMM, RES_ALU_OUT};
            MEM_W_RF:  ctrl = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                                SRC_A_REG_1, SRC_B_EXT_IMM, RES_MEM_DATA};
            EXEC_R:    ctrl = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                                SRC_A_REG_1, SRC_B_REG_2, RES_ALU_OUT};
            EXEC_I:    ctrl = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                                SRC_A_REG_1, SRC_B_EXT_IMM, RES_ALU_OUT};
            ALU_W_RF:  ctrl = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                                SRC_A_REG_1, SRC_B_REG_2, RES_ALU_OUT};
            BRANCH:    ctrl = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                                SRC_A_REG_1, SRC_B_REG_2, RES_ALU_OUT};
            default:   ctrl = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                                SRC_A_PC, SRC_B_FOUR, RES_ALU_OUT};
        endcase
    end

    assign rf_we      = ctrl.rf_we;
    assign m_we       = ctrl.m_we;
    assign en_ir      = ctrl.en_ir;
    assign en_npc_r   = ctrl.en_npc_r;
    assign m_addr_src = ctrl.m_addr_src;
    assign alu_src_a  = ctrl.src_a;
    assign alu_src_b  = ctrl.src_b;
    assign res_src    = ctrl.res;
    assign dt         = DT_WORD;
    assign halted     = (state == HALT);

    always_comb begin
        case (state)
            DECODE:   imm_src = IMM_B; // Branch target is built here.
            MEM_ADDR: imm_src = (op == OP_STORE) ? IMM_S : IMM_I;
            EXEC_I:   imm_src = IMM_I;
            default:  imm_src = IMM_NONE;
        endcase
    end

    rv_alu_decoder u_alu_decoder (
        .op       (op),
        .funct3   (funct3),
        .funct7   (funct7),
        .alu_ctrl (dec_alu_ctrl)
    );

    always_comb begin
        case (state)
            EXEC_R, EXEC_I: alu_ctrl = dec_alu_ctrl;
            BRANCH:         alu_ctrl = ALU_SUB;
            default:        alu_ctrl = ALU_ADD;
        endcase
    end

    // Flags are {zero, negative, carry, overflow}.
    assign zero = alu_flags[3];
    assign less = alu_flags[2] ^ alu_flags[0];

    always_comb begin
        case (funct3)
            3'b000:  taken = zero;
            3'b001:  taken = !zero;
            3'b100:  taken = less;
            3'b101:  taken = !less;
            default: taken = 1'b0;
        endcase
    end

    assign en_pc = (state == FETCH) || ((state == BRANCH) && taken);

    //////////////////////////////////////////////////
    // Assertions

    a_store_path: assert property (@(posedge clk) disable iff (rst)
        m_we |-> (state == MEM_WRITE) && ($past(state) == MEM_ADDR));

    a_halt_hold: assert property (@(posedge clk) disable iff (rst)
        (state == HALT) |=> (state == HALT));

endmodule

// ==== source/rv_datapath.sv ====
`timescale 1ns/10ps
`include "rv_mc_cfg.svh"

module rv_datapath
    import rv_mc_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                rf_we,
    input  logic                m_we,
    input  logic                en_ir,
    input  logic                en_npc_r,
    input  logic                en_pc,
    input  logic                m_addr_src,
    input  alu_src_a_e          alu_src_a,
    input  alu_src_b_e          alu_src_b,
    input  res_src_e            res_src,
    input  imm_src_e            imm_src,
    input  alu_op_e             alu_ctrl,
    input  mem_dt_e             dt,
    input  logic [`RV_XLEN-1:0] m_rdata,
    output logic [`RV_XLEN-1:0] instr,
    output logic [3:0]          alu_flags,
    output logic [`RV_XLEN-1:0] m_addr,
    output logic [`RV_XLEN-1:0] m_wdata
);

    localparam int RAW = $clog2(`RV_NREGS);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] old_pc;
    logic [`RV_XLEN-1:0] ir;
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] rf_a;
    logic [`RV_XLEN-1:0] rf_b;
    logic [`RV_XLEN-1:0] reg_a;
    logic [`RV_XLEN-1:0] reg_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] mdr;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] result;
    logic [RAW-1:0]      rs1;
    logic [RAW-1:0]      rs2;
    logic [RAW-1:0]      rd;

    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];
    assign rd  = ir[11:7];

    //////////////////////////////////////////////////
    // Program counter and instruction registers

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
            ir <= '0;
        end else begin
            if (en_pc) begin
                pc <= result;
            end
            if (en_ir) begin
                ir <= m_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_ir) begin
            old_pc <= pc; // Base for the branch target in DECODE.
        end
    end

    //////////////////////////////////////////////////
    // Register file and holding registers

    always_ff @(posedge clk) begin
        if (rf_we && rd != '0) begin
            regs[rd] <= result;
        end
    end

    assign rf_a = (rs1 == '0) ? '0 : regs[rs1];
    assign rf_b = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        reg_a <= rf_a;
        reg_b <= rf_b;
        mdr   <= m_rdata;
        if (en_npc_r) begin
            alu_out <= alu_result;
        end
    end

    always_comb begin
        case (imm_src)
            IMM_I:   imm = {{(`RV_XLEN-12){ir[31]}}, ir[31:20]};
            IMM_S:   imm = {{(`RV_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
            IMM_B:   imm = {{(`RV_XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        case (alu_src_a)
            SRC_A_PC:     src_a = pc;
            SRC_A_OLD_PC: src_a = old_pc;
            default:      src_a = reg_a;
        endcase
    end

    always_comb begin
        case (alu_src_b)
            SRC_B_REG_2:   src_b = reg_b;
            SRC_B_EXT_IMM: src_b = imm;
            default:       src_b = `RV_XLEN'(4);
        endcase
    end

    rv_alu #(
        .WIDTH (`RV_XLEN)
    ) u_alu (
        .a        (src_a),
        .b        (src_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    always_comb begin
        case (res_src)
            RES_ALU_RESULT: result = alu_result;
            RES_MEM_DATA:   result = mdr;
            default:        result = alu_out;
        endcase
    end

    assign instr   = ir;
    assign m_addr  = m_addr_src ? alu_out : pc;
    assign m_wdata = reg_b;

    a_store_aligned: assert property (@(posedge clk) disable iff (rst)
        (m_we && dt == DT_WORD) |-> (m_addr[1:0] == 2'b00));

endmodule

// ==== source/rv_mc_core.sv ====
`timescale 1ns/10ps
`include "rv_mc_cfg.svh"

module rv_mc_core
    import rv_mc_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [`RV_XLEN-1:0] m_rdata,
    output logic [`RV_XLEN-1:0] m_addr,
    output logic [`RV_XLEN-1:0] m_wdata,
    output logic                m_we,
    output logic                halted
);

    logic                rf_we;
    logic                en_ir;
    logic                en_pc;
    logic                en_npc_r;
    logic                m_addr_src;
    alu_src_a_e          alu_src_a;
    alu_src_b_e          alu_src_b;
    res_src_e            res_src;
    imm_src_e            imm_src;
    alu_op_e             alu_ctrl;
    mem_dt_e             dt;
    logic [`RV_XLEN-1:0] instr;
    logic [3:0]          alu_flags;

    rv_mc_controller u_controller (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .rf_we      (rf_we),
        .m_we       (m_we),
        .en_ir      (en_ir),
        .en_pc      (en_pc),
        .en_npc_r   (en_npc_r),
        .m_addr_src (m_addr_src),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .dt         (dt),
        .halted     (halted)
    );

    rv_datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .rf_we      (rf_we),
        .m_we       (m_we),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .en_pc      (en_pc),
        .m_addr_src (m_addr_src),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .dt         (dt),
        .m_rdata    (m_rdata),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .m_addr     (m_addr),
        .m_wdata    (m_wdata)
    );

endmodule

// ==== dv/rv_tb_mem.sv ====
`timescale 1ns/10ps

module rv_tb_mem #(
    parameter int WORDS = 256
) (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];

    assign rdata = mem[addr[AW+1:2]]; // Same-cycle read, word addressed.

    always @(posedge clk) begin
        if (we) begin
            mem[addr[AW+1:2]] <= wdata;
            log_addr.push_back(addr); // Every store is kept in order.
            log_data.push_back(wdata);
        end
    end

    task automatic clear_all();
        int i;
        for (i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
        log_addr.delete();
        log_data.delete();
    endtask

    task automatic write_word(input logic [31:0] a, input logic [31:0] d);
        mem[a[AW+1:2]] = d;
    endtask

    function automatic int store_count();
        return log_addr.size();
    endfunction

    task automatic get_store(input int k, output logic [31:0] a, output logic [31:0] d);
        a = log_addr[k];
        d = log_data[k];
    endtask

endmodule

// ==== dv/rv_mc_tb.sv ====
`timescale 1ns/10ps
`include "rv_mc_cfg.svh"

module rv_mc_tb;

    localparam int          NT         = 8;
    localparam int          MAX_INSTR  = 12;
    localparam int          MAX_ST     = 16;
    localparam int          CLK_PERIOD = 40;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [31:0] DATA_BASE  = 32'h0000_0100;
    localparam logic [31:0] HALT_WORD  = 32'h0000_0073; // ecall is not implemented.

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    logic [`RV_XLEN-1:0] m_rdata;
    logic [`RV_XLEN-1:0] m_addr;
    logic [`RV_XLEN-1:0] m_wdata;
    logic                m_we;
    logic                halted;

    string       test_name [NT];
    logic [31:0] prog [NT][MAX_INSTR];
    int          n_instr [NT];
    logic [31:0] data_word [NT][2];
    logic [31:0] exp_st_addr [NT][MAX_ST];
    logic [31:0] exp_st_data [NT][MAX_ST];
    int          exp_st_n [NT];
    int          exp_cycles [NT];

    int cur_test;
    int budget_cycles;
    int err_count;
    int pass_count;
    int fail_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_mc_core uut (
        .clk     (clk),
        .rst     (rst),
        .m_rdata (m_rdata),
        .m_addr  (m_addr),
        .m_wdata (m_wdata),
        .m_we    (m_we),
        .halted  (halted)
    );

    rv_tb_mem u_mem (
        .clk   (clk),
        .addr  (m_addr),
        .wdata (m_wdata),
        .we    (m_we),
        .rdata (m_rdata)
    );

    //////////////////////////////////////////////////
    // Instruction encoding

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    // Stores rs2 at imm(rs1).
    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    //////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] apply_op(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic reference_run(input int t);
        logic [31:0] x [32];
        logic [31:0] dmem [256];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic        taken;
        logic        done;
        int          i;
        int          steps;

        for (i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] = (i < n_instr[t]) ? prog[t][i] : '0;
        end
        dmem[DATA_BASE[9:2]]     = data_word[t][0];
        dmem[DATA_BASE[9:2] + 1] = data_word[t][1];
        pc            = `RV_RESET_PC;
        done          = 1'b0;
        steps         = 0;
        exp_st_n[t]   = 0;
        exp_cycles[t] = 0;
        while (!done && steps < 200) begin
            ins = dmem[pc[9:2]];
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            pc  = pc + 4;
            steps++;
            case (ins[6:0])
                7'b0110011: begin
                    x[ins[11:7]] = apply_op(ins[14:12], ins[30], a, b);
                    exp_cycles[t] += 4;
                end
                OPC_IMM: begin
                    x[ins[11:7]] = apply_op(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
                    exp_cycles[t] += 4;
                end
                OPC_LOAD: begin
                    ea = a + {{20{ins[31]}}, ins[31:20]};
                    x[ins[11:7]] = dmem[ea[9:2]];
                    exp_cycles[t] += 5;
                end
                7'b0100011: begin
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    dmem[ea[9:2]] = b;
                    if (exp_st_n[t] < MAX_ST) begin
                        exp_st_addr[t][exp_st_n[t]] = ea;
                        exp_st_data[t][exp_st_n[t]] = b;
                    end
                    exp_st_n[t]++;
                    exp_cycles[t] += 4;
                end
                7'b1100011: begin
                    case (ins[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        pc = pc - 4 + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                       ins[11:8], 1'b0};
                    end
                    exp_cycles[t] += 3;
                end
                default: begin
                    done = 1'b1; // Fetch and decode, then the core stops.
                    exp_cycles[t] += 2;
                end
            endcase
            x[0] = '0;
        end
    endtask

    //////////////////////////////////////////////////
    // Test table

    task automatic append_instr(input int t, input logic [31:0] w);
        prog[t][n_instr[t]] = w;
        n_instr[t]++;
    endtask

    task automatic append_operand_loads(input int t);
        append_instr(t, i_type(OPC_LOAD, 3'b010, 1, 0, DATA_BASE));
        append_instr(t, i_type(OPC_LOAD, 3'b010, 2, 0, DATA_BASE + 4));
    endtask

    task automatic build_table();
        int t;

        for (t = 0; t < NT; t++) begin
            n_instr[t] = 0;
            data_word[t][0] = $urandom();
            data_word[t][1] = $urandom();
        end

        test_name[0] = "r_arith";
        append_operand_loads(0);
        append_instr(0, r_type(7'h00, 3'b000, 3, 1, 2)); // add
        append_instr(0, s_type(3, 0, 32'h200));
        append_instr(0, r_type(7'h20, 3'b000, 3, 1, 2)); // sub
        append_instr(0, s_type(3, 0, 32'h204));
        append_instr(0, r_type(7'h00, 3'b010, 3, 1, 2)); // slt
        append_instr(0, s_type(3, 0, 32'h208));
        append_instr(0, r_type(7'h00, 3'b001, 3, 1, 2)); // sll
        append_instr(0, s_type(3, 0, 32'h20C));
        append_instr(0, HALT_WORD);

        test_name[1] = "r_logic";
        append_operand_loads(1);
        append_instr(1, r_type(7'h00, 3'b111, 3, 1, 2)); // and
        append_instr(1, s_type(3, 0, 32'h210));
        append_instr(1, r_type(7'h00, 3'b110, 3, 1, 2)); // or
        append_instr(1, s_type(3, 0, 32'h214));
        append_instr(1, r_type(7'h00, 3'b100, 3, 1, 2)); // xor
        append_instr(1, s_type(3, 0, 32'h218));
        append_instr(1, r_type(7'h00, 3'b101, 3, 1, 2)); // srl
        append_instr(1, s_type(3, 0, 32'h21C));
        append_instr(1, HALT_WORD);

        test_name[2] = "i_type";
        append_instr(2, i_type(OPC_LOAD, 3'b010, 1, 0, DATA_BASE));
        append_instr(2, i_type(OPC_IMM, 3'b000, 3, 1, -5));
        append_instr(2, s_type(3, 0, 32'h200));
        append_instr(2, i_type(OPC_IMM, 3'b111, 4, 1, -256));
        append_instr(2, s_type(4, 0, 32'h204));
        append_instr(2, i_type(OPC_IMM, 3'b110, 5, 1, -2048));
        append_instr(2, s_type(5, 0, 32'h208));
        append_instr(2, i_type(OPC_IMM, 3'b100, 6, 1, -1));
        append_instr(2, s_type(6, 0, 32'h20C));
        append_instr(2, i_type(OPC_IMM, 3'b010, 7, 1, -1));
        append_instr(2, s_type(7, 0, 32'h210));
        append_instr(2, HALT_WORD);

        test_name[3] = "memory";
        append_instr(3, i_type(OPC_LOAD, 3'b010, 1, 0, DATA_BASE));
        append_instr(3, i_type(OPC_IMM, 3'b000, 5, 0, 32'h300));
        append_instr(3, s_type(1, 5, 0));
        append_instr(3, i_type(OPC_LOAD, 3'b010, 2, 0, DATA_BASE + 4));
        append_instr(3, s_type(2, 5, -4));
        append_instr(3, i_type(OPC_LOAD, 3'b010, 4, 5, 0)); // Reads back the first store.
        append_instr(3, s_type(4, 5, 4));
        append_instr(3, i_type(OPC_IMM, 3'b000, 0, 1, 7));
        append_instr(3, r_type(7'h00, 3'b000, 0, 1, 1));
        append_instr(3, s_type(0, 5, 8));
        append_instr(3, HALT_WORD);

        test_name[4] = "loop_bne";
        append_instr(4, i_type(OPC_IMM, 3'b000, 1, 0, 3));
        append_instr(4, i_type(OPC_IMM, 3'b000, 2, 0, 32'h200));
        append_instr(4, s_type(1, 2, 0));
        append_instr(4, i_type(OPC_IMM, 3'b000, 2, 2, 4));
        append_instr(4, i_type(OPC_IMM, 3'b000, 1, 1, -1));
        append_instr(4, b_type(3'b001, 1, 0, -12));
        append_instr(4, HALT_WORD);

        test_name[5] = "loop_blt";
        append_instr(5, i_type(OPC_IMM, 3'b000, 1, 0, 2));
        append_instr(5, i_type(OPC_IMM, 3'b000, 2, 0, 32'h220));
        append_instr(5, s_type(1, 2, 0));
        append_instr(5, i_type(OPC_IMM, 3'b000, 2, 2, 4));
        append_instr(5, i_type(OPC_IMM, 3'b000, 1, 1, -1));
        append_instr(5, b_type(3'b100, 0, 1, -12)); // Loops while x1 is above zero.
        append_instr(5, HALT_WORD);

        test_name[6] = "beq_bge";
        append_instr(6, i_type(OPC_IMM, 3'b000, 1, 0, 5));
        append_instr(6, i_type(OPC_IMM, 3'b000, 2, 0, -3));
        append_instr(6, b_type(3'b000, 1, 2, 8));
        append_instr(6, s_type(1, 0, 32'h200));
        append_instr(6, b_type(3'b101, 1, 2, 8));
        append_instr(6, s_type(2, 0, 32'h204));
        append_instr(6, b_type(3'b000, 1, 1, 8));
        append_instr(6, s_type(1, 0, 32'h208));
        append_instr(6, b_type(3'b101, 2, 1, 8));
        append_instr(6, s_type(2, 0, 32'h20C));
        append_instr(6, HALT_WORD);

        test_name[7] = "halt_lui";
        append_instr(7, 32'h0000_10B7); // lui x1, 1
        append_instr(7, s_type(1, 0, 32'h200));
        append_instr(7, HALT_WORD);
    endtask

    //////////////////////////////////////////////////
    // Checks and test sequencing

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s, %s is %h, expected %h",
                     $time, test_name[cur_test], what, got, exp);
            err_count++;
        end
    endtask

    task automatic run_row(input int t);
        logic [31:0] st_addr;
        logic [31:0] st_data;
        int          cycles;
        int          errs_before;
        int          n_log;
        int          k;

        cur_test    = t;
        errs_before = err_count;
        rst         = 1'b1;
        u_mem.clear_all();
        for (k = 0; k < n_instr[t]; k++) begin
            u_mem.write_word(`RV_RESET_PC + 4 * k, prog[t][k]);
        end
        u_mem.write_word(DATA_BASE, data_word[t][0]);
        u_mem.write_word(DATA_BASE + 4, data_word[t][1]);
        repeat (3) @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
        end
        n_log = u_mem.store_count();
        check_value(n_log, exp_st_n[t], "store count");
        for (k = 0; k < n_log && k < exp_st_n[t] && k < MAX_ST; k++) begin
            u_mem.get_store(k, st_addr, st_data);
            check_value(st_addr, exp_st_addr[t][k], $sformatf("store %0d address", k));
            check_value(st_data, exp_st_data[t][k], $sformatf("store %0d data", k));
        end
        check_value(cycles, exp_cycles[t], "cycles to halt");
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %-9s ok, %0d cycles, %0d stores", test_name[t], cycles, n_log);
        end else begin
            fail_count++;
            $display("test %-9s failed with %0d mismatches", test_name[t],
                     err_count - errs_before);
        end
    endtask

    initial begin : watchdog
        wait (budget_cycles > 0);
        #(budget_cycles * CLK_PERIOD);
        $display("Timeout: test %s did not halt, run stopped after %0d cycles",
                 test_name[cur_test], budget_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int t;
        int budget;

        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        cur_test   = 0;
        budget     = 0;
        void'($urandom(95954));
        build_table();
        for (t = 0; t < NT; t++) begin
            reference_run(t);
            budget += 5 * n_instr[t] + 10;
        end
        budget_cycles = budget;
        for (t = 0; t < NT; t++) begin
            run_row(t);
        end
        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/rv_mc_pkg.sv
source/rv_alu_decoder.sv
source/rv_alu.sv
source/rv_mc_controller.sv
source/rv_datapath.sv
source/rv_mc_core.sv
dv/rv_tb_mem.sv
dv/rv_mc_tb.sv

// ==== Bender.yml ====
package:
  name: rv_mc_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/rv_mc_pkg.sv
      - source/rv_alu_decoder.sv
      - source/rv_alu.sv
      - source/rv_mc_controller.sv
      - source/rv_datapath.sv
      - source/rv_mc_core.sv
      - target: simulation
        files:
          - dv/rv_tb_mem.sv
          - dv/rv_mc_tb.sv
